/* flist.f */
+incdir+src
src/cmd_launch_pkg.sv
src/axi_lite_regs.sv
src/launch_ctrl_fsm.sv
src/delay_counter.sv
src/core_reset_timer.sv
src/cmd_launch_top.sv
verif/tb_clk_gen.sv
verif/tb_cmd_launch.sv

/* src/axi_lite_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmd_launch_config.svh"

module axi_lite_regs (
  input  logic                       user_clk,
  input  logic                       rst_n_i,
  input  logic [`CL_ADDR_W-1:0]      awaddr_i,
  input  logic                       awvalid_i,
  output logic                       awready_o,
  input  logic [`CL_WORD_W-1:0]      wdata_i,
  input  logic [3:0]                 wstrb_i,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  output logic [1:0]                 bresp_o,
  output logic                       bvalid_o,
  input  logic                       bready_i,
  input  logic [`CL_ADDR_W-1:0]      araddr_i,
  input  logic                       arvalid_i,
  output logic                       arready_o,
  output logic [`CL_WORD_W-1:0]      rdata_o,
  output logic [1:0]                 rresp_o,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  input  logic [`CL_WORD_W-1:0]      core_state0_i,
  input  logic [`CL_WORD_W-1:0]      core_state1_i,
  input  logic [`CL_WORD_W-1:0]      core_state2_i,
  input  logic [`CL_WORD_W-1:0]      core_state3_i,
  output logic                       doorbell_valid_o,
  output cmd_launch_pkg::doorbell_u  doorbell_o,
  output logic [`CL_WORD_W-1:0]      command_o,
  output logic [`CL_WORD_W-1:0]      data0_o,
  output logic [`CL_WORD_W-1:0]      data1_o,
  output logic [`CL_WORD_W-1:0]      delay_o
);

  logic                       wr_ready_q;
  logic                       bvalid_q;
  logic                       arready_q;
  logic                       rvalid_q;
  logic                       db_valid_q;
  logic                       wr_hs;
  logic                       rd_hs;
  cmd_launch_pkg::reg_idx_t   wr_idx;
  cmd_launch_pkg::reg_idx_t   rd_idx;
  cmd_launch_pkg::doorbell_u  doorbell_q;
  logic [`CL_WORD_W-1:0]      command_q;
  logic [`CL_WORD_W-1:0]      data0_q;
  logic [`CL_WORD_W-1:0]      data1_q;
  logic [`CL_WORD_W-1:0]      delay_q;
  logic [`CL_WORD_W-1:0]      rdata_q;
  logic [`CL_WORD_W-1:0]      status [`CL_REG_NUM];

  function automatic logic [`CL_WORD_W-1:0] merge_strb(
    input logic [`CL_WORD_W-1:0] old_word,
    input logic [`CL_WORD_W-1:0] new_word,
    input logic [3:0]            strb
  );
    logic [`CL_WORD_W-1:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        result[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return result;
  endfunction

  assign wr_idx = awaddr_i[4:2];
  assign rd_idx = araddr_i[4:2];
  assign wr_hs  = wr_ready_q && awvalid_i && wvalid_i;
  assign rd_hs  = arready_q && arvalid_i;

  always_ff @(posedge user_clk) begin
    if (!rst_n_i) begin
      wr_ready_q <= 1'b0;
      bvalid_q   <= 1'b0;
      db_valid_q <= 1'b0;
      arready_q  <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      // Address and data accepted together in one beat
      wr_ready_q <= !wr_ready_q && awvalid_i && wvalid_i && !bvalid_q;
      db_valid_q <= wr_hs && (wr_idx == 3'd0);
      if (wr_hs) begin
        bvalid_q <= 1'b1;
      end else if (bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_hs) begin
        rvalid_q <= 1'b1;
      end else if (rready_i) begin
        rvalid_q <= 1'b0;
      end
      // Next read accepted only once the current data is taken
      arready_q <= !(rd_hs || (rvalid_q && !rready_i));
    end
  end

  always_ff @(posedge user_clk) begin
    if (wr_hs) begin
      case (wr_idx)
        3'd0:    doorbell_q.raw <= merge_strb(doorbell_q.raw, wdata_i, wstrb_i);
        3'd1:    command_q <= merge_strb(command_q, wdata_i, wstrb_i);
        3'd2:    data0_q <= merge_strb(data0_q, wdata_i, wstrb_i);
        3'd3:    data1_q <= merge_strb(data1_q, wdata_i, wstrb_i);
        3'd4:    delay_q <= merge_strb(delay_q, wdata_i, wstrb_i);
        default: ;
      endcase
    end
  end

  // Status read map
  always_comb begin
    for (int i = 0; i < `CL_REG_NUM; i++) begin
      status[i] = '0;
    end
    status[0] = doorbell_q.raw;
    status[1] = core_state0_i;
    status[2] = core_state1_i;
    status[3] = core_state2_i;
    status[4] = core_state3_i;
  end

  always_ff @(posedge user_clk) begin
    if (rd_hs) begin
      rdata_q <= status[rd_idx];
    end
  end

  assign awready_o        = wr_ready_q;
  assign wready_o         = wr_ready_q;
  assign bresp_o          = 2'b00;
  assign bvalid_o         = bvalid_q;
  assign arready_o        = arready_q;
  assign rdata_o          = rdata_q;
  assign rresp_o          = 2'b00;
  assign rvalid_o         = rvalid_q;
  assign doorbell_valid_o = db_valid_q;
  assign doorbell_o       = doorbell_q;
  assign command_o        = command_q;
  assign data0_o          = data0_q;
  assign data1_o          = data1_q;
  assign delay_o          = delay_q;

endmodule

`default_nettype wire

/* src/cmd_launch_config.svh */
`ifndef CMD_LAUNCH_CONFIG_SVH
`define CMD_LAUNCH_CONFIG_SVH

// Host bus sizing
`define CL_WORD_W     32
`define CL_ADDR_W     32

// Register map
`define CL_REG_NUM    8
`define CL_REG_IDX_W  3

// Command credits toward the core
`define CL_CREDIT_MAX 2
`define CL_CREDIT_W   2

// Watchdog timing in user_clk cycles
`define CL_WDOG_LIMIT 64
`define CL_RST_PULSE  4

`endif

/* src/cmd_launch_pkg.sv */
`default_nettype none
`include "cmd_launch_config.svh"

package cmd_launch_pkg;

  typedef logic [`CL_REG_IDX_W-1:0] reg_idx_t;

  // Unlisted codes are ignored by the launcher
  typedef enum logic [7:0] {
    NONE       = 8'd0,
    LAUNCH     = 8'd1,
    WDOG_START = 8'd2,
    WDOG_KICK  = 8'd3
  } action_e;

  // Doorbell word kept raw for readback and decoded for the FSM
  typedef union packed {
    logic [`CL_WORD_W-1:0] raw;
    struct packed {
      logic [23:0] rsvd;
      action_e     action;
    } fields;
  } doorbell_u;

  typedef enum logic [1:0] {
    IDLE  = 2'd0,
    DELAY = 2'd1,
    ISSUE = 2'd2
  } launch_state_e;

endpackage

`default_nettype wire

/* src/cmd_launch_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmd_launch_config.svh"

module cmd_launch_top (
  input  logic                  user_clk,
  input  logic                  rst_n_i,
  input  logic [`CL_ADDR_W-1:0] awaddr_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  logic [`CL_WORD_W-1:0] wdata_i,
  input  logic [3:0]            wstrb_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  output logic [1:0]            bresp_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  input  logic [`CL_ADDR_W-1:0] araddr_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  output logic [`CL_WORD_W-1:0] rdata_o,
  output logic [1:0]            rresp_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  input  logic [`CL_WORD_W-1:0] core_state0_i,
  input  logic [`CL_WORD_W-1:0] core_state1_i,
  input  logic [`CL_WORD_W-1:0] core_state2_i,
  input  logic [`CL_WORD_W-1:0] core_state3_i,
  output logic                  cmd_valid_o,
  output logic [`CL_WORD_W-1:0] cmd_command_o,
  output logic [`CL_WORD_W-1:0] cmd_data0_o,
  output logic [`CL_WORD_W-1:0] cmd_data1_o,
  input  logic                  cmd_credit_i,
  output logic                  core_rst_o
);

  logic                      doorbell_valid;
  cmd_launch_pkg::doorbell_u doorbell;
  logic [`CL_WORD_W-1:0]     command;
  logic [`CL_WORD_W-1:0]     data0;
  logic [`CL_WORD_W-1:0]     data1;
  logic [`CL_WORD_W-1:0]     delay;
  logic                      delay_load;
  logic [`CL_WORD_W-1:0]     delay_value;
  logic                      delay_done;
  logic                      wdog_start;
  logic                      wdog_kick;

  axi_lite_regs u_regs (
    .user_clk         (user_clk),
    .rst_n_i          (rst_n_i),
    .awaddr_i         (awaddr_i),
    .awvalid_i        (awvalid_i),
    .awready_o        (awready_o),
    .wdata_i          (wdata_i),
    .wstrb_i          (wstrb_i),
    .wvalid_i         (wvalid_i),
    .wready_o         (wready_o),
    .bresp_o          (bresp_o),
    .bvalid_o         (bvalid_o),
    .bready_i         (bready_i),
    .araddr_i         (araddr_i),
    .arvalid_i        (arvalid_i),
    .arready_o        (arready_o),
    .rdata_o          (rdata_o),
    .rresp_o          (rresp_o),
    .rvalid_o         (rvalid_o),
    .rready_i         (rready_i),
    .core_state0_i    (core_state0_i),
    .core_state1_i    (core_state1_i),
    .core_state2_i    (core_state2_i),
    .core_state3_i    (core_state3_i),
    .doorbell_valid_o (doorbell_valid),
    .doorbell_o       (doorbell),
    .command_o        (command),
    .data0_o          (data0),
    .data1_o          (data1),
    .delay_o          (delay)
  );

  launch_ctrl_fsm u_fsm (
    .user_clk         (user_clk),
    .rst_n_i          (rst_n_i),
    .doorbell_valid_i (doorbell_valid),
    .doorbell_i       (doorbell),
    .command_i        (command),
    .data0_i          (data0),
    .data1_i          (data1),
    .delay_i          (delay),
    .delay_done_i     (delay_done),
    .cmd_credit_i     (cmd_credit_i),
    .delay_load_o     (delay_load),
    .delay_value_o    (delay_value),
    .wdog_start_o     (wdog_start),
    .wdog_kick_o      (wdog_kick),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_command_o    (cmd_command_o),
    .cmd_data0_o      (cmd_data0_o),
    .cmd_data1_o      (cmd_data1_o)
  );

  delay_counter u_delay (
    .user_clk     (user_clk),
    .rst_n_i      (rst_n_i),
    .load_i       (delay_load),
    .load_value_i (delay_value),
    .done_o       (delay_done)
  );

  core_reset_timer u_wdog (
    .user_clk   (user_clk),
    .rst_n_i    (rst_n_i),
    .start_i    (wdog_start),
    .kick_i     (wdog_kick),
    .core_rst_o (core_rst_o)
  );

endmodule

`default_nettype wire

/* src/core_reset_timer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmd_launch_config.svh"

module core_reset_timer (
  input  logic user_clk,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic kick_i,
  output logic core_rst_o
);

  localparam int CNT_END = `CL_WDOG_LIMIT + `CL_RST_PULSE;
  localparam int CNT_W   = $clog2(CNT_END);

  logic             running_q;
  logic [CNT_W-1:0] count_q;

  always_ff @(posedge user_clk) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (start_i || (kick_i && running_q)) begin
      running_q <= 1'b1;
      count_q   <= '0;
    end else if (running_q) begin
      // Stop after the last pulse cycle until the next start
      if (count_q == CNT_W'(CNT_END - 1)) begin
        running_q <= 1'b0;
        count_q   <= '0;
      end else begin
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Timeout window covers the reset pulse
  assign core_rst_o = running_q && (count_q >= CNT_W'(`CL_WDOG_LIMIT));

endmodule

`default_nettype wire

/* src/delay_counter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmd_launch_config.svh"

module delay_counter (
  input  logic                  user_clk,
  input  logic                  rst_n_i,
  input  logic                  load_i,
  input  logic [`CL_WORD_W-1:0] load_value_i,
  output logic                  done_o
);

  logic                  running_q;
  logic [`CL_WORD_W-1:0] count_q;

  always_ff @(posedge user_clk) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      count_q   <= '0;
    end else if (load_i) begin
      running_q <= 1'b1;
      count_q   <= load_value_i;
    end else if (running_q) begin
      if (count_q == '0) begin
        running_q <= 1'b0;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Done for a single cycle at zero
  assign done_o = running_q && (count_q == '0);

endmodule

`default_nettype wire

/* src/launch_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmd_launch_config.svh"

module launch_ctrl_fsm (
  input  logic                       user_clk,
  input  logic                       rst_n_i,
  input  logic                       doorbell_valid_i,
  input  cmd_launch_pkg::doorbell_u  doorbell_i,
  input  logic [`CL_WORD_W-1:0]      command_i,
  input  logic [`CL_WORD_W-1:0]      data0_i,
  input  logic [`CL_WORD_W-1:0]      data1_i,
  input  logic [`CL_WORD_W-1:0]      delay_i,
  input  logic                       delay_done_i,
  input  logic                       cmd_credit_i,
  output logic                       delay_load_o,
  output logic [`CL_WORD_W-1:0]      delay_value_o,
  output logic                       wdog_start_o,
  output logic                       wdog_kick_o,
  output logic                       cmd_valid_o,
  output logic [`CL_WORD_W-1:0]      cmd_command_o,
  output logic [`CL_WORD_W-1:0]      cmd_data0_o,
  output logic [`CL_WORD_W-1:0]      cmd_data1_o
);

  cmd_launch_pkg::launch_state_e state_q;
  cmd_launch_pkg::launch_state_e state_d;
  cmd_launch_pkg::action_e       action;
  logic [`CL_CREDIT_W-1:0]       credit_q;
  logic [`CL_WORD_W-1:0]         command_q;
  logic [`CL_WORD_W-1:0]         data0_q;
  logic [`CL_WORD_W-1:0]         data1_q;

  assign action = doorbell_i.fields.action;

  // Doorbell decode
  always_comb begin
    delay_load_o = 1'b0;
    wdog_start_o = 1'b0;
    wdog_kick_o  = 1'b0;
    if (doorbell_valid_i) begin
      case (action)
        cmd_launch_pkg::LAUNCH:     delay_load_o = (state_q == cmd_launch_pkg::IDLE);
        cmd_launch_pkg::WDOG_START: wdog_start_o = 1'b1;
        cmd_launch_pkg::WDOG_KICK:  wdog_kick_o = 1'b1;
        default:                    ;
      endcase
    end
  end

  assign delay_value_o = delay_i;
  assign cmd_valid_o   = (state_q == cmd_launch_pkg::ISSUE) && (credit_q != '0);

  always_comb begin
    state_d = state_q;
    case (state_q)
      cmd_launch_pkg::IDLE:  if (delay_load_o) state_d = cmd_launch_pkg::DELAY;
      cmd_launch_pkg::DELAY: if (delay_done_i) state_d = cmd_launch_pkg::ISSUE;
      cmd_launch_pkg::ISSUE: if (cmd_valid_o) state_d = cmd_launch_pkg::IDLE;
      default:               state_d = cmd_launch_pkg::IDLE;
    endcase
  end

  always_ff @(posedge user_clk) begin
    if (!rst_n_i) begin
      state_q  <= cmd_launch_pkg::IDLE;
      credit_q <= `CL_CREDIT_W'(`CL_CREDIT_MAX);
    end else begin
      state_q <= state_d;
      // Issue and return in one cycle cancel out
      case ({cmd_valid_o, cmd_credit_i})
        2'b10: credit_q <= credit_q - 1'b1;
        2'b01: begin
          if (credit_q < `CL_CREDIT_W'(`CL_CREDIT_MAX)) begin
            credit_q <= credit_q + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  // Command words frozen at launch
  always_ff @(posedge user_clk) begin
    if (delay_load_o) begin
      command_q <= command_i;
      data0_q   <= data0_i;
      data1_q   <= data1_i;
    end
  end

  assign cmd_command_o = command_q;
  assign cmd_data0_o   = data0_q;
  assign cmd_data1_o   = data1_q;

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic user_clk,
  output logic rst_n_o
);

  initial begin
    user_clk = 1'b0;
    forever #(PERIOD_NS / 2) user_clk = ~user_clk;
  end

  // Reset released just after a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge user_clk);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* verif/tb_cmd_launch.sv */
`timescale 1ns/1ps
`default_nettype none
`include "cmd_launch_config.svh"

module tb_cmd_launch;

  localparam int DRIVE_DLY = 1;
  localparam int WAIT_MAX  = 200;

  logic                  user_clk;
  logic                  rst_n;
  logic [`CL_ADDR_W-1:0] awaddr;
  logic                  awvalid;
  logic                  awready;
  logic [`CL_WORD_W-1:0] wdata;
  logic [3:0]            wstrb;
  logic                  wvalid;
  logic                  wready;
  logic [1:0]            bresp;
  logic                  bvalid;
  logic                  bready;
  logic [`CL_ADDR_W-1:0] araddr;
  logic                  arvalid;
  logic                  arready;
  logic [`CL_WORD_W-1:0] rdata;
  logic [1:0]            rresp;
  logic                  rvalid;
  logic                  rready;
  logic [`CL_WORD_W-1:0] core_state [4];
  logic                  cmd_valid;
  logic [`CL_WORD_W-1:0] cmd_command;
  logic [`CL_WORD_W-1:0] cmd_data0;
  logic [`CL_WORD_W-1:0] cmd_data1;
  logic                  cmd_credit;
  logic                  core_rst;
  int                    cycle_cnt = 0;
  int                    cmd_cnt = 0;
  int                    err_cnt = 0;
  logic [31:0]           lfsr_state = 32'h67a3_3575;

  tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(4)) u_clk_gen (
    .user_clk (user_clk),
    .rst_n_o  (rst_n)
  );

  cmd_launch_top DUT (
    .user_clk      (user_clk),
    .rst_n_i       (rst_n),
    .awaddr_i      (awaddr),
    .awvalid_i     (awvalid),
    .awready_o     (awready),
    .wdata_i       (wdata),
    .wstrb_i       (wstrb),
    .wvalid_i      (wvalid),
    .wready_o      (wready),
    .bresp_o       (bresp),
    .bvalid_o      (bvalid),
    .bready_i      (bready),
    .araddr_i      (araddr),
    .arvalid_i     (arvalid),
    .arready_o     (arready),
    .rdata_o       (rdata),
    .rresp_o       (rresp),
    .rvalid_o      (rvalid),
    .rready_i      (rready),
    .core_state0_i (core_state[0]),
    .core_state1_i (core_state[1]),
    .core_state2_i (core_state[2]),
    .core_state3_i (core_state[3]),
    .cmd_valid_o   (cmd_valid),
    .cmd_command_o (cmd_command),
    .cmd_data0_o   (cmd_data0),
    .cmd_data1_o   (cmd_data1),
    .cmd_credit_i  (cmd_credit),
    .core_rst_o    (core_rst)
  );

  always @(posedge user_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Core side view of issued commands
  always @(negedge user_clk) begin
    if (rst_n && cmd_valid) begin
      cmd_cnt <= cmd_cnt + 1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int nbits);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  task automatic fail_stop(input string what);
    err_cnt++;
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      fail_stop($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_doorbell(input string name, input cmd_launch_pkg::doorbell_u exp,
                                input cmd_launch_pkg::doorbell_u act);
    if (exp.raw !== act.raw) begin
      fail_stop($sformatf("[FAIL] %s expected %h actual %h", name, exp.raw, act.raw));
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      fail_stop($sformatf("[FAIL] %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge user_clk);
    #DRIVE_DLY;
  endtask

  task automatic axi_write(input string name, input logic [31:0] addr,
                           input logic [31:0] data, output int hs_cycle);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = 4'hf;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!awready) begin
      if (n >= WAIT_MAX) begin
        fail_stop($sformatf("Timeout in %s: write address was never accepted", name));
      end else begin
        next_cycle();
        n++;
      end
    end
    check_flag({name, " wready"}, 1'b1, wready);
    // Handshake edge
    next_cycle();
    hs_cycle = cycle_cnt;
    awvalid  = 1'b0;
    wvalid   = 1'b0;
    bready   = 1'b1;
    n = 0;
    while (!bvalid) begin
      if (n >= WAIT_MAX) begin
        fail_stop($sformatf("Timeout in %s: no write response came back", name));
      end else begin
        next_cycle();
        n++;
      end
    end
    check_word({name, " bresp"}, 32'd0, 32'(bresp));
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic axi_read(input string name, input logic [31:0] addr,
                          output logic [31:0] data);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      if (n >= WAIT_MAX) begin
        fail_stop($sformatf("Timeout in %s: read address was never accepted", name));
      end else begin
        next_cycle();
        n++;
      end
    end
    next_cycle();
    arvalid = 1'b0;
    rready  = 1'b1;
    n = 0;
    while (!rvalid) begin
      if (n >= WAIT_MAX) begin
        fail_stop($sformatf("Timeout in %s: no read data came back", name));
      end else begin
        next_cycle();
        n++;
      end
    end
    data = rdata;
    check_word({name, " rresp"}, 32'd0, 32'(rresp));
    next_cycle();
    rready = 1'b0;
  endtask

  task automatic launch(input string name, input logic [31:0] cmd, input logic [31:0] d0,
                        input logic [31:0] d1, input logic [31:0] dly, output int hs_cycle);
    cmd_launch_pkg::doorbell_u db;
    int                        unused_hs;
    db.raw          = '0;
    db.fields.rsvd  = 24'(rand_bits(24));
    db.fields.action = cmd_launch_pkg::LAUNCH;
    axi_write(name, 32'h04, cmd, unused_hs);
    axi_write(name, 32'h08, d0, unused_hs);
    axi_write(name, 32'h0c, d1, unused_hs);
    axi_write(name, 32'h10, dly, unused_hs);
    axi_write(name, 32'h00, db.raw, hs_cycle);
  endtask

  task automatic wait_cmd(input string name, input int max_cycles, input int hs_cycle,
                          output int latency);
    int n;
    n = 0;
    while (!cmd_valid) begin
      if (n >= max_cycles) begin
        fail_stop($sformatf("Timeout in %s: no command was issued", name));
      end else begin
        next_cycle();
        n++;
      end
    end
    // Pulse is taken by the core at the next edge
    latency = cycle_cnt + 1 - hs_cycle;
  endtask

  task automatic wait_rst_rise(input string name, input int hs_cycle, output int latency);
    int n;
    n = 0;
    while (!core_rst) begin
      if (n >= WAIT_MAX) begin
        fail_stop($sformatf("Timeout in %s: core reset never rose", name));
      end else begin
        next_cycle();
        n++;
      end
    end
    latency = cycle_cnt + 1 - hs_cycle;
  endtask

  task automatic measure_rst_width(input string name, output int width);
    width = 0;
    while (core_rst) begin
      if (width >= 4 * `CL_RST_PULSE) begin
        fail_stop($sformatf("Timeout in %s: core reset stuck high", name));
      end else begin
        next_cycle();
        width++;
      end
    end
  endtask

  task automatic return_credit();
    cmd_credit = 1'b1;
    next_cycle();
    cmd_credit = 1'b0;
  endtask

  task automatic expect_quiet(input string name, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      check_flag({name, " cmd_valid"}, 1'b0, cmd_valid);
      check_flag({name, " core_rst"}, 1'b0, core_rst);
      next_cycle();
    end
  endtask

  task automatic test_reset();
    check_flag("reset cmd_valid", 1'b0, cmd_valid);
    check_flag("reset core_rst", 1'b0, core_rst);
    check_flag("reset bvalid", 1'b0, bvalid);
    check_flag("reset rvalid", 1'b0, rvalid);
  endtask

  task automatic test_reg_map();
    cmd_launch_pkg::doorbell_u db;
    cmd_launch_pkg::doorbell_u rd_db;
    logic [31:0]               rd;
    int                        hs;
    axi_write("regmap", 32'h04, rand_bits(32), hs);
    axi_write("regmap", 32'h08, rand_bits(32), hs);
    axi_write("regmap", 32'h0c, rand_bits(32), hs);
    axi_write("regmap", 32'h10, rand_bits(32), hs);
    db.raw = {24'(rand_bits(24)), 8'h00};
    axi_write("regmap", 32'h00, db.raw, hs);
    axi_read("regmap", 32'h00, rd);
    rd_db.raw = rd;
    check_doorbell("regmap doorbell", db, rd_db);
    for (int i = 1; i <= 4; i++) begin
      axi_read("regmap", 32'(i * 4), rd);
      check_word($sformatf("regmap state%0d", i - 1), core_state[i - 1], rd);
    end
    for (int i = 5; i < `CL_REG_NUM; i++) begin
      axi_read("regmap", 32'(i * 4), rd);
      check_word($sformatf("regmap index%0d", i), 32'd0, rd);
    end
    expect_quiet("regmap", 10);
  endtask

  task automatic test_launch();
    logic [31:0] cmd;
    logic [31:0] d0;
    logic [31:0] d1;
    logic [31:0] dly;
    int          hs;
    int          lat;
    int          start_cnt;
    cmd       = rand_bits(32);
    d0        = rand_bits(32);
    d1        = rand_bits(32);
    dly       = rand_bits(4) + 1;
    start_cnt = cmd_cnt;
    launch("launch", cmd, d0, d1, dly, hs);
    wait_cmd("launch", WAIT_MAX, hs, lat);
    check_word("launch latency", dly + 3, 32'(lat));
    check_word("launch command", cmd, cmd_command);
    check_word("launch data0", d0, cmd_data0);
    check_word("launch data1", d1, cmd_data1);
    next_cycle();
    check_flag("launch single pulse", 1'b0, cmd_valid);
    check_word("launch pulse count", 32'(start_cnt + 1), 32'(cmd_cnt));
    return_credit();
  endtask

  task automatic test_credits();
    logic [31:0] cmd;
    logic [31:0] d0;
    logic [31:0] d1;
    int          hs;
    int          lat;
    int          start_cnt;
    start_cnt = cmd_cnt;
    for (int k = 0; k < `CL_CREDIT_MAX; k++) begin
      launch("credits", rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(3) + 1, hs);
      wait_cmd("credits", WAIT_MAX, hs, lat);
      next_cycle();
    end
    check_word("credits issued", 32'(start_cnt + `CL_CREDIT_MAX), 32'(cmd_cnt));
    // Third command stalls without credits
    cmd = rand_bits(32);
    d0  = rand_bits(32);
    d1  = rand_bits(32);
    launch("credits stall", cmd, d0, d1, rand_bits(3) + 1, hs);
    for (int i = 0; i < 100; i++) begin
      check_flag("credits stall cmd_valid", 1'b0, cmd_valid);
      next_cycle();
    end
    return_credit();
    wait_cmd("credits resume", 10, hs, lat);
    check_word("credits resume command", cmd, cmd_command);
    check_word("credits resume data0", d0, cmd_data0);
    check_word("credits resume data1", d1, cmd_data1);
    next_cycle();
    check_flag("credits single pulse", 1'b0, cmd_valid);
    check_word("credits total", 32'(start_cnt + `CL_CREDIT_MAX + 1), 32'(cmd_cnt));
    return_credit();
    return_credit();
  endtask

  task automatic test_watchdog();
    int hs;
    int lat;
    int width;
    axi_write("wdog start", 32'h00, {24'(rand_bits(24)), 8'h02}, hs);
    wait_rst_rise("wdog start", hs, lat);
    check_word("wdog start latency", 32'(`CL_WDOG_LIMIT + 2), 32'(lat));
    measure_rst_width("wdog start", width);
    check_word("wdog pulse width", 32'(`CL_RST_PULSE), 32'(width));
    expect_quiet("wdog stopped", 20);
    axi_write("wdog restart", 32'h00, {24'(rand_bits(24)), 8'h02}, hs);
    expect_quiet("wdog before kick", 20);
    axi_write("wdog kick", 32'h00, {24'(rand_bits(24)), 8'h03}, hs);
    wait_rst_rise("wdog kick", hs, lat);
    check_word("wdog kick latency", 32'(`CL_WDOG_LIMIT + 2), 32'(lat));
    measure_rst_width("wdog kick", width);
    check_word("wdog kick pulse width", 32'(`CL_RST_PULSE), 32'(width));
  endtask

  task automatic test_ignored();
    logic [31:0] cmd;
    logic [31:0] d0;
    logic [31:0] d1;
    int          hs;
    int          hs2;
    int          lat;
    int          start_cnt;
    start_cnt = cmd_cnt;
    axi_write("unknown action", 32'h00, {24'(rand_bits(24)), 8'h5a}, hs);
    expect_quiet("unknown action", 100);
    check_word("unknown action count", 32'(start_cnt), 32'(cmd_cnt));
    cmd = rand_bits(32);
    d0  = rand_bits(32);
    d1  = rand_bits(32);
    launch("double launch", cmd, d0, d1, 32'd60, hs);
    launch("double launch", rand_bits(32), rand_bits(32), rand_bits(32), 32'd5, hs2);
    wait_cmd("double launch", WAIT_MAX, hs, lat);
    check_word("double launch latency", 32'd63, 32'(lat));
    check_word("double launch command", cmd, cmd_command);
    check_word("double launch data0", d0, cmd_data0);
    check_word("double launch data1", d1, cmd_data1);
    next_cycle();
    expect_quiet("double launch after", 100);
    check_word("double launch count", 32'(start_cnt + 1), 32'(cmd_cnt));
    return_credit();
  endtask

  initial begin
    int n;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = 4'h0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    cmd_credit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      core_state[i] = rand_bits(32);
    end
    n = 0;
    while (rst_n !== 1'b1) begin
      if (n >= 20) begin
        fail_stop("Timeout: reset was never released");
      end else begin
        next_cycle();
        n++;
      end
    end
    next_cycle();
    test_reset();
    test_reg_map();
    test_launch();
    test_credits();
    test_watchdog();
    test_ignored();
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
